// ==== rtl/hydra_settings.svh ====
`ifndef HYDRA_SETTINGS_SVH
`define HYDRA_SETTINGS_SVH

// ######################################################################
// Switch dimensions
// ######################################################################

`define HYDRA_PORTS        4   // Input ports, output ports and banks
`define HYDRA_SLOTS        4   // Packet slots per bank
`define HYDRA_SLOT_WORDS   64  // Also the longest packet

// ######################################################################
// Queueing and data path
// ######################################################################

`define HYDRA_PRIORS       4   // 3 is the highest
`define HYDRA_QUEUE_DEPTH  16  // Holds every slot of the switch
`define HYDRA_DATA_W       16

`endif

// ==== rtl/hydra_pkg.sv ====
`default_nettype none
`include "hydra_settings.svh"

package hydra_pkg;

    typedef logic [1:0] port_idx_t;
    typedef logic [1:0] slot_idx_t;

    // One bus word, read as payload or as packet header
    typedef union packed {
        logic [`HYDRA_DATA_W-1:0] raw;
        struct packed {
            port_idx_t  dest;
            logic [1:0] prio;
            logic [6:0] count;  // Total words with header, 2..64
            logic [4:0] rsvd;
        } hdr;
    } word_u;

    // Descriptor of one stored packet, 15 bits
    typedef struct packed {
        port_idx_t  bank;
        slot_idx_t  slot;
        logic [6:0] count;
        logic [1:0] prio;
        port_idx_t  dest;
    } pkt_desc_t;

endpackage

`default_nettype wire

// ==== rtl/port_wr_frontend.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module port_wr_frontend #(
    parameter hydra_pkg::port_idx_t BANK_ID = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_sop,
    input  logic                   wr_eop,
    input  logic                   wr_vld,
    input  hydra_pkg::word_u       wr_data,
    input  logic [`HYDRA_SLOTS-1:0] free_map,
    output logic                   pause,
    output logic                   wr_en,
    output logic [7:0]             wr_addr,
    output hydra_pkg::word_u       wr_word,
    output logic [`HYDRA_SLOTS-1:0] slot_claim,
    output logic                   desc_push,
    output hydra_pkg::pkt_desc_t   desc_in
);
    import hydra_pkg::*;

    logic      busy;        // Packet in progress
    slot_idx_t free_slot;
    slot_idx_t slot_q;
    word_u     hdr_q;       // Header of the current packet
    logic [5:0] cnt;
    logic      take_sop;
    logic      take_word;

    assign take_sop  = wr_vld & wr_sop;
    assign take_word = wr_vld & (wr_sop | busy);

    // Never rises mid packet
    assign pause = ~busy & ~(|free_map);

    // Lowest free slot
    always_comb begin
        free_slot = '0;
        for (int i = `HYDRA_SLOTS - 1; i >= 0; i--) begin
            if (free_map[i]) free_slot = slot_idx_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            wr_en      <= 1'b0;
            slot_claim <= '0;
            desc_push  <= 1'b0;
        end else begin
            wr_en      <= take_word;
            slot_claim <= take_sop ? (`HYDRA_SLOTS'(1) << free_slot) : '0;
            desc_push  <= take_word & wr_eop;   // Lands in the bank one edge later
            if (take_sop) begin
                busy <= ~wr_eop;
            end else if (take_word && wr_eop) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_word <= wr_data;
        if (take_sop) begin
            slot_q  <= free_slot;
            hdr_q   <= wr_data;
            cnt     <= 6'd1;
            wr_addr <= {free_slot, 6'd0};
        end else if (take_word) begin
            cnt     <= cnt + 6'd1;
            wr_addr <= {slot_q, cnt};
        end
        desc_in.bank  <= BANK_ID;
        desc_in.slot  <= slot_q;
        desc_in.count <= hdr_q.hdr.count;
        desc_in.prio  <= hdr_q.hdr.prio;
        desc_in.dest  <= hdr_q.hdr.dest;
    end

endmodule

`default_nettype wire

// ==== rtl/packet_bank.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module packet_bank #(
    parameter hydra_pkg::port_idx_t BANK_ID = '0
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     wr_en,
    input  logic [7:0]                               wr_addr,
    input  hydra_pkg::word_u                         wr_word,
    input  logic [`HYDRA_SLOTS-1:0]                  slot_claim,
    input  logic                                     desc_push,
    input  hydra_pkg::pkt_desc_t                     desc_in,
    input  logic [`HYDRA_PORTS-1:0]                  grant,
    input  logic [`HYDRA_PORTS-1:0][7:0]             rd_addr,
    input  logic [`HYDRA_PORTS-1:0]                  slot_release,
    input  hydra_pkg::port_idx_t [`HYDRA_PORTS-1:0]  release_bank,
    input  hydra_pkg::slot_idx_t [`HYDRA_PORTS-1:0]  release_slot,
    output hydra_pkg::word_u [`HYDRA_PORTS-1:0]      rd_word,
    output logic [`HYDRA_SLOTS-1:0]                  free_map,
    output logic                                     desc_valid,
    output hydra_pkg::pkt_desc_t                     desc_head
);
    import hydra_pkg::*;

    localparam int WORDS = `HYDRA_SLOTS * `HYDRA_SLOT_WORDS;

    // ######################################################################
    // Packet storage, one registered read port per output
    // ######################################################################

    word_u mem [0:WORDS-1];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_word;
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < `HYDRA_PORTS; r++) begin
            rd_word[r] <= mem[rd_addr[r]];
        end
    end

    // ######################################################################
    // Slot free map
    // ######################################################################

    logic [`HYDRA_SLOTS-1:0] rel_mask;

    always_comb begin
        rel_mask = '0;
        for (int r = 0; r < `HYDRA_PORTS; r++) begin
            if (slot_release[r] && release_bank[r] == BANK_ID) begin
                rel_mask[release_slot[r]] = 1'b1;   // Only our own releases
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            free_map <= (free_map & ~slot_claim) | rel_mask;
        end
    end

    // ######################################################################
    // Pending descriptors, one entry per slot
    // ######################################################################

    pkt_desc_t  pend [0:`HYDRA_SLOTS-1];
    logic [2:0] wp;
    logic [2:0] rp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wp <= '0;
            rp <= '0;
        end else begin
            if (desc_push) wp <= wp + 3'd1;
            if (|grant)    rp <= rp + 3'd1;   // Taken by the destination's queue
        end
    end

    always_ff @(posedge clk) begin
        if (desc_push) pend[wp[1:0]] <= desc_in;
    end

    assign desc_valid = (wp != rp);
    assign desc_head  = pend[rp[1:0]];

endmodule

`default_nettype wire

// ==== rtl/port_queue_manager.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module port_queue_manager #(
    parameter hydra_pkg::port_idx_t PORT_ID = '0
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`HYDRA_PORTS-1:0]                 desc_valid,
    input  hydra_pkg::pkt_desc_t [`HYDRA_PORTS-1:0] desc_head,
    input  logic                                    deq,
    output logic [`HYDRA_PORTS-1:0]                 grant,
    output logic                                    q_valid,
    output hydra_pkg::pkt_desc_t                    q_desc
);
    import hydra_pkg::*;

    localparam int QW = $clog2(`HYDRA_QUEUE_DEPTH);

    // ######################################################################
    // Enqueue arbiter, round-robin over the banks
    // ######################################################################

    logic [`HYDRA_PORTS-1:0] req;
    port_idx_t rr;
    port_idx_t cand;
    port_idx_t gnt_idx;
    logic      gnt_any;
    pkt_desc_t gnt_desc;

    always_comb begin
        gnt_idx = '0;
        gnt_any = 1'b0;
        cand    = '0;
        for (int k = 0; k < `HYDRA_PORTS; k++) begin
            req[k] = desc_valid[k] && desc_head[k].dest == PORT_ID;
        end
        for (int k = 0; k < `HYDRA_PORTS; k++) begin
            cand = rr + port_idx_t'(k);
            if (!gnt_any && req[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cand;
            end
        end
    end

    assign grant    = gnt_any ? (`HYDRA_PORTS'(1) << gnt_idx) : '0;
    assign gnt_desc = desc_head[gnt_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr <= '0;
        end else if (gnt_any) begin
            rr <= gnt_idx + 2'd1;   // Winner goes last next time
        end
    end

    // ######################################################################
    // Priority FIFOs, strict priority on the way out
    // ######################################################################

    pkt_desc_t qmem [`HYDRA_PRIORS][`HYDRA_QUEUE_DEPTH];
    logic [QW:0] wp [`HYDRA_PRIORS];
    logic [QW:0] rp [`HYDRA_PRIORS];
    logic [`HYDRA_PRIORS-1:0] nonempty;
    logic [1:0] sel;

    always_comb begin
        sel = '0;
        for (int p = 0; p < `HYDRA_PRIORS; p++) begin
            nonempty[p] = (wp[p] != rp[p]);
            if (nonempty[p]) sel = 2'(p);   // Highest wins
        end
    end

    assign q_valid = |nonempty;
    assign q_desc  = qmem[sel][rp[sel][QW-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `HYDRA_PRIORS; p++) begin
                wp[p] <= '0;
                rp[p] <= '0;
            end
        end else begin
            if (gnt_any) wp[gnt_desc.prio] <= wp[gnt_desc.prio] + 1'b1;
            if (deq)     rp[sel] <= rp[sel] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_any) qmem[gnt_desc.prio][wp[gnt_desc.prio][QW-1:0]] <= gnt_desc;
    end

endmodule

`default_nettype wire

// ==== rtl/port_rd_frontend.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module port_rd_frontend (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ready,
    input  logic                                q_valid,
    input  hydra_pkg::pkt_desc_t                q_desc,
    input  hydra_pkg::word_u [`HYDRA_PORTS-1:0] bank_word,
    output logic                                deq,
    output logic [7:0]                          rd_addr,
    output logic                                slot_release,
    output hydra_pkg::port_idx_t                release_bank,
    output hydra_pkg::slot_idx_t                release_slot,
    output logic                                rd_sop,
    output logic                                rd_eop,
    output logic                                rd_vld,
    output logic [`HYDRA_DATA_W-1:0]            rd_data
);
    import hydra_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_STREAM = 2'd1;   // Issuing addresses
    localparam logic [1:0] S_DRAIN  = 2'd2;   // Last word still in the pipe

    logic [1:0] state;
    pkt_desc_t  cur;
    logic [5:0] cnt;
    logic       last;
    logic       v1;
    logic       s1;
    logic       e1;

    assign deq  = (state == S_IDLE) && ready && q_valid;   // ready only matters here
    assign last = ({1'b0, cnt} == cur.count - 7'd1);

    assign rd_addr      = {cur.slot, cnt};
    assign release_bank = cur.bank;
    assign release_slot = cur.slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            v1           <= 1'b0;
            s1           <= 1'b0;
            e1           <= 1'b0;
            rd_vld       <= 1'b0;
            rd_sop       <= 1'b0;
            rd_eop       <= 1'b0;
            slot_release <= 1'b0;
        end else begin
            // Stage 1 waits on the bank read, stage 2 is the output
            v1     <= (state == S_STREAM);
            s1     <= (state == S_STREAM) && cnt == 6'd0;
            e1     <= (state == S_STREAM) && last;
            rd_vld <= v1;
            rd_sop <= s1;
            rd_eop <= e1;
            slot_release <= (state == S_STREAM) && last;
            case (state)
                S_IDLE:   if (deq)  state <= S_STREAM;
                S_STREAM: if (last) state <= S_DRAIN;
                S_DRAIN:  if (e1)   state <= S_IDLE;   // Idle in the rd_eop cycle
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            cur <= q_desc;
            cnt <= 6'd0;
        end else if (state == S_STREAM) begin
            cnt <= cnt + 6'd1;
        end
        rd_data <= bank_word[cur.bank].raw;   // Bank picked here
    end

endmodule

`default_nettype wire

// ==== rtl/hydra.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module hydra (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [`HYDRA_PORTS-1:0]                   wr_sop,
    input  logic [`HYDRA_PORTS-1:0]                   wr_eop,
    input  logic [`HYDRA_PORTS-1:0]                   wr_vld,
    input  logic [`HYDRA_PORTS-1:0][`HYDRA_DATA_W-1:0] wr_data,
    output logic [`HYDRA_PORTS-1:0]                   pause,
    output logic                                      full,
    output logic                                      almost_full,
    input  logic [`HYDRA_PORTS-1:0]                   ready,
    output logic [`HYDRA_PORTS-1:0]                   rd_sop,
    output logic [`HYDRA_PORTS-1:0]                   rd_eop,
    output logic [`HYDRA_PORTS-1:0]                   rd_vld,
    output logic [`HYDRA_PORTS-1:0][`HYDRA_DATA_W-1:0] rd_data
);
    import hydra_pkg::*;

    localparam int NP = `HYDRA_PORTS;
    localparam int NS = `HYDRA_SLOTS;

    // Write side, one per bank
    logic [NP-1:0]            wr_en;
    logic [NP-1:0][7:0]       wr_addr;
    word_u [NP-1:0]           wr_word;
    logic [NP-1:0][NS-1:0]    slot_claim;
    logic [NP-1:0]            desc_push;
    pkt_desc_t [NP-1:0]       desc_in;
    logic [NP-1:0][NS-1:0]    free_map;
    logic [NP-1:0]            desc_valid;
    pkt_desc_t [NP-1:0]       desc_head;

    // qm_grant[q][b] from queue manager q, bank_grant[b][q] into bank b
    logic [NP-1:0][NP-1:0]    qm_grant;
    logic [NP-1:0][NP-1:0]    bank_grant;

    // Read side, one per output
    logic [NP-1:0]            deq;
    logic [NP-1:0]            q_valid;
    pkt_desc_t [NP-1:0]       q_desc;
    logic [NP-1:0][7:0]       rd_addr;
    logic [NP-1:0]            slot_release;
    port_idx_t [NP-1:0]       release_bank;
    slot_idx_t [NP-1:0]       release_slot;
    word_u [NP-1:0][NP-1:0]   bank_rd;    // [bank][reader]
    word_u [NP-1:0][NP-1:0]   reader_rd;  // [reader][bank]

    for (genvar p = 0; p < NP; p++) begin : g_port
        for (genvar q = 0; q < NP; q++) begin : g_xbar
            assign bank_grant[p][q] = qm_grant[q][p];
            assign reader_rd[p][q]  = bank_rd[q][p];
        end

        port_wr_frontend #(.BANK_ID(port_idx_t'(p))) u_wr (
            .clk, .rst_n,
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]),
            .wr_data(wr_data[p]), .free_map(free_map[p]), .pause(pause[p]),
            .wr_en(wr_en[p]), .wr_addr(wr_addr[p]), .wr_word(wr_word[p]),
            .slot_claim(slot_claim[p]), .desc_push(desc_push[p]), .desc_in(desc_in[p])
        );

        packet_bank #(.BANK_ID(port_idx_t'(p))) u_bank (
            .clk, .rst_n,
            .wr_en(wr_en[p]), .wr_addr(wr_addr[p]), .wr_word(wr_word[p]),
            .slot_claim(slot_claim[p]), .desc_push(desc_push[p]), .desc_in(desc_in[p]),
            .grant(bank_grant[p]), .rd_addr(rd_addr),
            .slot_release(slot_release), .release_bank(release_bank),
            .release_slot(release_slot), .rd_word(bank_rd[p]),
            .free_map(free_map[p]), .desc_valid(desc_valid[p]), .desc_head(desc_head[p])
        );

        port_queue_manager #(.PORT_ID(port_idx_t'(p))) u_qm (
            .clk, .rst_n,
            .desc_valid(desc_valid), .desc_head(desc_head), .deq(deq[p]),
            .grant(qm_grant[p]), .q_valid(q_valid[p]), .q_desc(q_desc[p])
        );

        port_rd_frontend u_rd (
            .clk, .rst_n,
            .ready(ready[p]), .q_valid(q_valid[p]), .q_desc(q_desc[p]),
            .bank_word(reader_rd[p]), .deq(deq[p]), .rd_addr(rd_addr[p]),
            .slot_release(slot_release[p]), .release_bank(release_bank[p]),
            .release_slot(release_slot[p]), .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]),
            .rd_vld(rd_vld[p]), .rd_data(rd_data[p])
        );
    end

    // ######################################################################
    // Status flags from the free slot count
    // ######################################################################

    logic [$clog2(NP*NS):0] free_cnt;

    always_comb begin
        free_cnt = '0;
        for (int b = 0; b < NP; b++) begin
            for (int s = 0; s < NS; s++) begin
                free_cnt = free_cnt + free_map[b][s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full        <= (free_cnt == '0);
            almost_full <= (free_cnt <= (NP * NS) / 2);   // Half or less left
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_hydra.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "hydra_settings.svh"

module tb_hydra;
    import hydra_pkg::*;

    localparam int NP         = `HYDRA_PORTS;
    localparam int NPR        = `HYDRA_PRIORS;
    localparam int SW         = `HYDRA_SLOT_WORDS;
    localparam int MAXP       = 256;    // Packets over the whole run
    localparam int PKTS_A     = 30;     // Random packets per input
    localparam int WAIT_LIMIT = 5000;

    logic                         clk;
    logic                         rst_n;
    logic [NP-1:0]                wr_sop;
    logic [NP-1:0]                wr_eop;
    logic [NP-1:0]                wr_vld;
    logic [NP-1:0][`HYDRA_DATA_W-1:0] wr_data;
    logic [NP-1:0]                pause;
    logic                         full;
    logic                         almost_full;
    logic [NP-1:0]                ready;
    logic [NP-1:0]                rd_sop;
    logic [NP-1:0]                rd_eop;
    logic [NP-1:0]                rd_vld;
    logic [NP-1:0][`HYDRA_DATA_W-1:0] rd_data;

    hydra u_dut (
        .clk, .rst_n,
        .wr_sop, .wr_eop, .wr_vld, .wr_data,
        .pause, .full, .almost_full,
        .ready, .rd_sop, .rd_eop, .rd_vld, .rd_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ######################################################################
    // Reference model state
    // ######################################################################

    int    seed = 52457;
    word_u pkt_mem [MAXP*SW];       // Words of every packet sent
    int    pkt_len [MAXP];
    int    pkt_gap [MAXP];          // Idle cycles before sop
    int    exp_q [NP*NP*NPR][$];    // Per (source, destination, priority)
    int    src_q [NP][$];           // Send order per input
    int    tx_total;
    int    rx_total;

    word_u      rx_buf [NP][SW];
    logic       rx_eop [NP][SW];    // rd_eop seen with each word
    int         rx_cnt [NP];
    logic       in_pkt [NP];
    logic       order_check [NP];
    logic [1:0] last_prio [NP];

    int value_errs;
    int proto_errs;
    int timeout_errs;

    // ######################################################################
    // Compare tasks and the closing report
    // ######################################################################

    task automatic check_word(input string name, input word_u got, input word_u exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s got %h exp %h", name, got.raw, exp.raw);
        end
    endtask

    task automatic check_desc_hdr(input string name, input word_u got, input word_u exp);
        if (got.hdr.dest !== exp.hdr.dest || got.hdr.prio !== exp.hdr.prio ||
            got.hdr.count !== exp.hdr.count) begin
            value_errs++;
            $display("FAILED %s got dest %h prio %h count %h exp dest %h prio %h count %h",
                     name, got.hdr.dest, got.hdr.prio, got.hdr.count,
                     exp.hdr.dest, exp.hdr.prio, exp.hdr.count);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs == 0 && proto_errs == 0 && timeout_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // ######################################################################
    // Stimulus
    // ######################################################################

    task automatic make_packet(input int src, input int dst, input int prio, input int max_len);
        int          id;
        int          len;
        word_u       w;
        logic [31:0] rnd;
        id  = tx_total;
        rnd = $random(seed);
        len = 2 + int'(rnd[15:0]) % (max_len - 1);
        w.hdr.dest  = dst[1:0];
        w.hdr.prio  = prio[1:0];
        w.hdr.count = len[6:0];
        w.hdr.rsvd  = rnd[20:16];
        pkt_mem[id*SW] = w;
        w.raw = {src[1:0], id[13:0]};       // Source and sequence number
        pkt_mem[id*SW+1] = w;
        for (int i = 2; i < len; i++) begin
            rnd = $random(seed);
            pkt_mem[id*SW+i].raw = rnd[15:0];
        end
        pkt_len[id] = len;
        pkt_gap[id] = int'(rnd[25:24]);
        exp_q[src*NP*NPR + dst*NPR + prio].push_back(id);
        src_q[src].push_back(id);
        tx_total++;
    endtask

    // dst_fixed below zero means a random destination
    task automatic gen_traffic(input int count, input int dst_fixed, input int max_len);
        logic [31:0] rnd;
        int          dst;
        for (int k = 0; k < count; k++) begin
            for (int s = 0; s < NP; s++) begin
                rnd = $random(seed);
                dst = (dst_fixed < 0) ? int'(rnd[1:0]) : dst_fixed;
                make_packet(s, dst, int'(rnd[3:2]), max_len);
            end
        end
    endtask

    task automatic send_packet(input int src, input int id);
        int t;
        int n;
        repeat (pkt_gap[id] + 1) @(negedge clk);
        t = 0;
        while (pause[src] && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (pause[src]) begin
            timeout_errs++;
            $display("timeout: input %0d held pause for %0d cycles", src, t);
            return;
        end
        n = pkt_len[id];
        for (int i = 0; i < n; i++) begin
            if (i > 0) @(negedge clk);
            wr_vld[src]  = 1'b1;
            wr_sop[src]  = (i == 0);
            wr_eop[src]  = (i == n - 1);
            wr_data[src] = pkt_mem[id*SW+i].raw;
        end
        @(negedge clk);
        wr_vld[src] = 1'b0;
        wr_sop[src] = 1'b0;
        wr_eop[src] = 1'b0;
    endtask

    task automatic run_source(input int src, input int count);
        int id;
        for (int k = 0; k < count; k++) begin
            id = src_q[src].pop_front();
            send_packet(src, id);
        end
    endtask

    task automatic run_all(input int count);
        fork
            run_source(0, count);
            run_source(1, count);
            run_source(2, count);
            run_source(3, count);
        join
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (rx_total < tx_total && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (rx_total < tx_total) begin
            timeout_errs++;
            $display("timeout: only %0d of %0d packets left the switch", rx_total, tx_total);
        end
    endtask

    task automatic check_flags(input logic [NP-1:0] exp_pause, input logic exp_full,
                               input logic exp_af);
        for (int p = 0; p < NP; p++) begin
            check_flag($sformatf("pause[%0d]", p), pause[p], exp_pause[p]);
        end
        check_flag("full", full, exp_full);
        check_flag("almost_full", almost_full, exp_af);
    endtask

    // ######################################################################
    // Output monitor
    // ######################################################################

    task automatic finish_packet(input int p);
        word_u hdr;
        int    n;
        int    src;
        int    idx;
        int    id;
        hdr = rx_buf[p][0];
        n   = rx_cnt[p];
        rx_total++;
        if (n < 2) begin
            proto_errs++;
            $display("protocol error: output %0d sent a packet of %0d words", p, n);
            return;
        end
        src = int'(rx_buf[p][1].raw[15:14]);
        idx = src*NP*NPR + p*NPR + int'(hdr.hdr.prio);
        if (exp_q[idx].size() == 0) begin
            proto_errs++;
            $display("protocol error: output %0d sent an unexpected packet from input %0d",
                     p, src);
            return;
        end
        id = exp_q[idx].pop_front();
        check_desc_hdr($sformatf("rd_data[%0d] header", p), hdr, pkt_mem[id*SW]);
        for (int i = 0; i < n; i++) begin
            if (i < pkt_len[id]) begin
                check_word($sformatf("rd_data[%0d] word %0d", p, i), rx_buf[p][i],
                           pkt_mem[id*SW+i]);
            end
            check_flag($sformatf("rd_eop[%0d] word %0d", p, i), rx_eop[p][i],
                       i == pkt_len[id] - 1);
        end
        if (order_check[p]) begin
            if (hdr.hdr.prio > last_prio[p]) begin
                proto_errs++;
                $display("protocol error: output %0d sent priority %0d after %0d",
                         p, hdr.hdr.prio, last_prio[p]);
            end
            last_prio[p] = hdr.hdr.prio;
        end
    endtask

    task automatic sample_output(input int p);
        if (!rd_vld[p]) begin
            if (in_pkt[p]) begin
                proto_errs++;
                $display("protocol error: rd_vld dropped inside a packet on output %0d", p);
                in_pkt[p] = 1'b0;
            end
            check_flag($sformatf("rd_sop[%0d]", p), rd_sop[p], 1'b0);
            check_flag($sformatf("rd_eop[%0d]", p), rd_eop[p], 1'b0);
            return;
        end
        if (rd_sop[p]) begin
            if (in_pkt[p]) begin
                proto_errs++;
                $display("protocol error: rd_sop inside a packet on output %0d", p);
            end
            in_pkt[p] = 1'b1;
            rx_cnt[p] = 0;
        end else if (!in_pkt[p]) begin
            proto_errs++;
            $display("protocol error: rd_vld without rd_sop on output %0d", p);
            return;
        end
        rx_buf[p][rx_cnt[p]] = rd_data[p];
        rx_eop[p][rx_cnt[p]] = rd_eop[p];
        rx_cnt[p]++;
        if (rd_eop[p] || rx_cnt[p] == SW) begin
            in_pkt[p] = 1'b0;
            finish_packet(p);
        end
    endtask

    // DUT outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            for (int p = 0; p < NP; p++) begin
                sample_output(p);
            end
        end
    end

    // ######################################################################
    // Test sequence
    // ######################################################################

    initial begin
        logic [31:0] rnd;
        logic        a_done;
        int          left;
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '1;
        tx_total = 0;
        rx_total = 0;
        value_errs   = 0;
        proto_errs   = 0;
        timeout_errs = 0;
        for (int p = 0; p < NP; p++) begin
            rx_cnt[p]      = 0;
            in_pkt[p]      = 1'b0;
            order_check[p] = 1'b0;
            last_prio[p]   = 2'd3;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Everything idle right after reset
        @(negedge clk);
        check_flags('0, 1'b0, 1'b0);
        for (int p = 0; p < NP; p++) begin
            check_flag($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
        end

        // Random traffic, ready toggling on every output
        gen_traffic(PKTS_A, -1, SW);
        a_done = 1'b0;
        fork
            begin
                run_all(PKTS_A);
                a_done = 1'b1;
            end
            begin
                while (!a_done) begin
                    @(negedge clk);
                    rnd   = $random(seed);
                    ready = rnd[3:0] | rnd[7:4];   // Mostly high
                end
                ready = '1;
            end
        join
        wait_drain();

        // Output 0 held off, then strict priority on release
        ready = 4'b1110;
        gen_traffic(3, 0, 16);
        run_all(3);
        repeat (24) @(negedge clk);    // Enqueue takes at most a few cycles each
        order_check[0] = 1'b1;
        last_prio[0]   = 2'd3;
        ready[0]       = 1'b1;
        wait_drain();
        order_check[0] = 1'b0;

        // Fill every slot with all outputs stalled
        ready = '0;
        gen_traffic(5, -1, 20);
        run_all(1);
        repeat (3) @(negedge clk);
        check_flags('0, 1'b0, 1'b0);
        run_all(1);
        repeat (3) @(negedge clk);
        check_flags('0, 1'b0, 1'b1);   // 8 slots taken
        run_all(2);
        repeat (3) @(negedge clk);
        check_flags('1, 1'b1, 1'b1);
        fork
            run_all(1);                // Blocked by pause until ready returns
            begin
                repeat (10) @(negedge clk);
                check_flags('1, 1'b1, 1'b1);
                ready = '1;
            end
        join
        wait_drain();
        repeat (4) @(negedge clk);
        check_flags('0, 1'b0, 1'b0);

        left = 0;
        for (int q = 0; q < NP*NP*NPR; q++) begin
            left += exp_q[q].size();
        end
        if (left != 0) begin
            proto_errs++;
            $display("protocol error: %0d packets never left the switch", left);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/hydra_pkg.sv
rtl/port_wr_frontend.sv
rtl/packet_bank.sv
rtl/port_queue_manager.sv
rtl/port_rd_frontend.sv
rtl/hydra.sv
tb/tb_hydra.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the hydra switch testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_hydra \
    -f verilog.f -o tb_hydra > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_hydra > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$SIM_LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0
